/* logic/intra_size_pkg.sv */
package intra_size_pkg;

  // luma block sizes of one 64x64 unit
  typedef enum logic [1:0] {
    SIZE_04 = 2'd0,
    SIZE_08 = 2'd1,
    SIZE_16 = 2'd2,
    SIZE_32 = 2'd3
  } block_size_e;

  // z-order position in 4x4 units
  localparam int unsigned POS_W   = 8;
  // column or row index in 4x4 units
  localparam int unsigned COORD_W = 4;
  localparam int unsigned MODE_W  = 6;

  // ------------------------------
  // partition word layout
  // ------------------------------
  // bit 0 is the 64 split, then the 32, 16 and 8 split fields
  localparam int unsigned PART_W      = 85;
  localparam int unsigned PART_32_LSB = 1;
  localparam int unsigned PART_16_LSB = 5;
  localparam int unsigned PART_08_LSB = 21;

  // z-order distance to the next block of the same size
  function automatic logic [POS_W-1:0] pos_step(block_size_e size);
    logic [POS_W-1:0] step;
    case (size)
      SIZE_04: step = 8'd1;
      SIZE_08: step = 8'd4;
      SIZE_16: step = 8'd16;
      default: step = 8'd64;
    endcase
    return step;
  endfunction

endpackage

/* logic/intra_ctrl_pkg.sv */
package intra_ctrl_pkg;

  // controller state, luma only
  typedef enum logic {
    IDLE  = 1'b0,
    ENC_Y = 1'b1
  } ctrl_state_e;

  // prediction beat counter
  localparam int unsigned PRE_CNT_W = 5;

  // ------------------------------
  // prediction burst
  // ------------------------------
  // one beat covers two 4x4 columns, so a burst is (size*size)/32 beats
  // the function gives the index of the final beat
  function automatic logic [PRE_CNT_W-1:0] burst_last(
    intra_size_pkg::block_size_e size
  );
    logic [PRE_CNT_W-1:0] last;
    case (size)
      intra_size_pkg::SIZE_04: last = 5'd0;
      intra_size_pkg::SIZE_08: last = 5'd1;
      intra_size_pkg::SIZE_16: last = 5'd7;
      default:                 last = 5'd31;
    endcase
    return last;
  endfunction

endpackage

/* logic/intra_quadtree_walker.sv */
`timescale 1ns/100ps

module intra_quadtree_walker (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                start_i,
  input  logic                                ref_done_i,
  input  logic [intra_size_pkg::PART_W-1:0]   partition_i,
  output logic                                step_o,
  output logic [intra_size_pkg::POS_W-1:0]    next_pos_o,
  output intra_size_pkg::block_size_e         next_size_o,
  output logic                                done_o
);

  import intra_size_pkg::*;
  import intra_ctrl_pkg::*;

  ctrl_state_e       state_r;
  logic [POS_W-1:0]  cur_pos_r;
  block_size_e       cur_size_r;
  logic [POS_W-1:0]  nxt_pos_w;
  logic              last_w;
  logic              split_32_w;
  logic              split_16_w;
  logic              split_08_w;

  // ------------------------------
  // next position and last block
  // ------------------------------
  // a fresh walk starts at 0, otherwise step past the current block
  assign nxt_pos_w = (state_r == IDLE) ? '0 : cur_pos_r + pos_step(cur_size_r);

  // the sum wraps to 0 after the final block of the unit
  assign last_w = (state_r == ENC_Y) && (nxt_pos_w == '0);

  assign step_o = ((state_r == IDLE) && start_i) ||
                  ((state_r == ENC_Y) && ref_done_i && !last_w);

  // ------------------------------
  // leaf choice
  // ------------------------------
  // the 64 split bit is taken as set and never read
  assign split_32_w = partition_i[PART_32_LSB + nxt_pos_w[7:6]];
  assign split_16_w = partition_i[PART_16_LSB + nxt_pos_w[7:4]];
  assign split_08_w = partition_i[PART_08_LSB + nxt_pos_w[7:2]];

  always_comb begin
    if (!split_32_w) begin
      next_size_o = SIZE_32;
    end else if (!split_16_w) begin
      next_size_o = SIZE_16;
    end else if (!split_08_w) begin
      next_size_o = SIZE_08;
    end else begin
      next_size_o = SIZE_04;
    end
  end

  assign next_pos_o = nxt_pos_w;

  // state
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r <= IDLE;
    end else if ((state_r == IDLE) && start_i) begin
      state_r <= ENC_Y;
    end else if (ref_done_i && last_w) begin
      state_r <= IDLE;
    end
  end

  // block being walked
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cur_pos_r  <= '0;
      cur_size_r <= SIZE_04;
    end else if (step_o) begin
      cur_pos_r  <= nxt_pos_w;
      cur_size_r <= next_size_o;
    end
  end

  // done follows the ref_done of the last block
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      done_o <= 1'b0;
    end else begin
      done_o <= ref_done_i && last_w;
    end
  end

endmodule

/* logic/intra_block_info_reg.sv */
`timescale 1ns/100ps

module intra_block_info_reg (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                step_i,
  input  logic [intra_size_pkg::POS_W-1:0]    next_pos_i,
  input  intra_size_pkg::block_size_e         next_size_i,
  input  logic [intra_size_pkg::MODE_W-1:0]   md_data_i,
  output logic                                md_cena_o,
  output logic                                ref_start_o,
  output logic [intra_size_pkg::POS_W-1:0]    md_addr_o,
  output intra_size_pkg::block_size_e         loop_size_o,
  output logic [intra_size_pkg::POS_W-1:0]    loop_position_o,
  output logic [intra_size_pkg::MODE_W-1:0]   loop_mode_o
);

  import intra_size_pkg::*;

  logic               start_r;
  logic [POS_W-1:0]   block_pos_r;
  block_size_e        block_size_r;
  logic               md_cena_r;
  logic [MODE_W-1:0]  block_mode_r;

  // ------------------------------
  // block start
  // ------------------------------
  // one strobe both fetches the mode and starts the reference
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      start_r <= 1'b0;
    end else begin
      start_r <= step_i;
    end
  end

  // block info, held until the next step
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      block_pos_r  <= '0;
      block_size_r <= SIZE_04;
    end else if (step_i) begin
      block_pos_r  <= next_pos_i;
      block_size_r <= next_size_i;
    end
  end

  // ------------------------------
  // mode capture
  // ------------------------------
  // memory answers one cycle after the enable
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      md_cena_r <= 1'b0;
    end else begin
      md_cena_r <= start_r;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      block_mode_r <= '0;
    end else if (md_cena_r) begin
      block_mode_r <= md_data_i;
    end
  end

  // mode memory is addressed by z-order position
  assign md_cena_o       = start_r;
  assign ref_start_o     = start_r;
  assign md_addr_o       = block_pos_r;
  assign loop_position_o = block_pos_r;
  assign loop_size_o     = block_size_r;
  assign loop_mode_o     = block_mode_r;

endmodule

/* logic/intra_pred_sequencer.sv */
`timescale 1ns/100ps

module intra_pred_sequencer (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                ref_ready_i,
  input  intra_size_pkg::block_size_e         loop_size_i,
  input  logic [intra_size_pkg::POS_W-1:0]    loop_position_i,
  output logic                                pre_start_o,
  output logic [intra_size_pkg::COORD_W-1:0]  pre_4x4_x_o,
  output logic [intra_size_pkg::COORD_W-1:0]  pre_4x4_y_o
);

  import intra_size_pkg::*;
  import intra_ctrl_pkg::*;

  logic [PRE_CNT_W-1:0]  pre_cnt_r;
  logic                  last_beat_w;
  logic [COORD_W-1:0]    org_x_w;
  logic [COORD_W-1:0]    org_y_w;

  // z-order position splits into column (even bits) and row (odd bits)
  assign org_x_w = {loop_position_i[6], loop_position_i[4],
                    loop_position_i[2], loop_position_i[0]};
  assign org_y_w = {loop_position_i[7], loop_position_i[5],
                    loop_position_i[3], loop_position_i[1]};

  assign last_beat_w = (pre_cnt_r == burst_last(loop_size_i));

  // ------------------------------
  // burst control
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pre_start_o <= 1'b0;
    end else if (ref_ready_i) begin
      pre_start_o <= 1'b1;
    end else if (last_beat_w) begin
      pre_start_o <= 1'b0;
    end
  end

  // beat counter, cleared between bursts
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pre_cnt_r <= '0;
    end else if (pre_start_o && !last_beat_w) begin
      pre_cnt_r <= pre_cnt_r + 1'b1;
    end else begin
      pre_cnt_r <= '0;
    end
  end

  // ------------------------------
  // 4x4 coordinate stepping
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pre_4x4_x_o <= '0;
      pre_4x4_y_o <= '0;
    end else if (!pre_start_o || last_beat_w) begin
      pre_4x4_x_o <= org_x_w;
      pre_4x4_y_o <= org_y_w;
    end else begin
      case (loop_size_i)
        // two columns wide, one row per beat
        SIZE_08: pre_4x4_y_o <= pre_4x4_y_o + 1'b1;
        SIZE_16: begin
          if (pre_4x4_x_o[1:0] == 2'b10) begin
            pre_4x4_x_o <= org_x_w;
            pre_4x4_y_o <= pre_4x4_y_o + 1'b1;
          end else begin
            pre_4x4_x_o <= pre_4x4_x_o + 4'd2;
          end
        end
        SIZE_32: begin
          if (pre_4x4_x_o[2:0] == 3'b110) begin
            pre_4x4_x_o <= org_x_w;
            pre_4x4_y_o <= pre_4x4_y_o + 1'b1;
          end else begin
            pre_4x4_x_o <= pre_4x4_x_o + 4'd2;
          end
        end
        // single beat for 4x4, nothing to step
        default: pre_4x4_x_o <= org_x_w;
      endcase
    end
  end

endmodule

/* logic/intra_ctrl.sv */
`timescale 1ns/100ps

module intra_ctrl (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                start_i,
  input  logic [intra_size_pkg::PART_W-1:0]   partition_i,
  output logic                                md_cena_o,
  output logic [intra_size_pkg::POS_W-1:0]    md_addr_o,
  input  logic [intra_size_pkg::MODE_W-1:0]   md_data_i,
  output intra_size_pkg::block_size_e         loop_size_o,
  output logic [intra_size_pkg::POS_W-1:0]    loop_position_o,
  output logic [intra_size_pkg::MODE_W-1:0]   loop_mode_o,
  output logic                                ref_start_o,
  input  logic                                ref_done_i,
  input  logic                                ref_ready_i,
  output logic                                pre_start_o,
  output logic [intra_size_pkg::COORD_W-1:0]  pre_4x4_x_o,
  output logic [intra_size_pkg::COORD_W-1:0]  pre_4x4_y_o,
  output logic                                done_o
);

  import intra_size_pkg::*;

  logic              step_w;
  logic [POS_W-1:0]  next_pos_w;
  block_size_e       next_size_w;

  // walks the quadtree and announces each leaf
  intra_quadtree_walker u_walker (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .ref_done_i  (ref_done_i),
    .partition_i (partition_i),
    .step_o      (step_w),
    .next_pos_o  (next_pos_w),
    .next_size_o (next_size_w),
    .done_o      (done_o)
  );

  // latches the leaf, fetches its mode
  intra_block_info_reg u_info (
    .clk             (clk),
    .rstn            (rstn),
    .step_i          (step_w),
    .next_pos_i      (next_pos_w),
    .next_size_i     (next_size_w),
    .md_data_i       (md_data_i),
    .md_cena_o       (md_cena_o),
    .ref_start_o     (ref_start_o),
    .md_addr_o       (md_addr_o),
    .loop_size_o     (loop_size_o),
    .loop_position_o (loop_position_o),
    .loop_mode_o     (loop_mode_o)
  );

  // prediction burst once the reference is in
  intra_pred_sequencer u_pred (
    .clk             (clk),
    .rstn            (rstn),
    .ref_ready_i     (ref_ready_i),
    .loop_size_i     (loop_size_o),
    .loop_position_i (loop_position_o),
    .pre_start_o     (pre_start_o),
    .pre_4x4_x_o     (pre_4x4_x_o),
    .pre_4x4_y_o     (pre_4x4_y_o)
  );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  localparam int unsigned HALF_PERIOD_NS = 20;
  localparam int unsigned RESET_CYCLES   = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // release just after an edge, like every other input
  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rstn_o = 1'b1;
  end

endmodule

/* tb/tb_intra_ctrl.sv */
`timescale 1ns/100ps

module tb_intra_ctrl;

  import intra_size_pkg::*;

  localparam int unsigned NAME_W = 8 * 24;
  localparam int unsigned LINE_W = 8 * 160;

  logic clk;
  logic rstn;
  logic start_i;
  logic [PART_W-1:0] partition_i;
  logic md_cena_o;
  logic [POS_W-1:0] md_addr_o;
  logic [MODE_W-1:0] md_data_i;
  block_size_e loop_size_o;
  logic [POS_W-1:0] loop_position_o;
  logic [MODE_W-1:0] loop_mode_o;
  logic ref_start_o;
  logic ref_done_i;
  logic ref_ready_i;
  logic pre_start_o;
  logic [COORD_W-1:0] pre_4x4_x_o;
  logic [COORD_W-1:0] pre_4x4_y_o;
  logic done_o;

  logic [MODE_W-1:0] mode_mem [256];
  logic [POS_W-1:0] exp_pos [256];
  block_size_e exp_size [256];
  int exp_count;
  logic [NAME_W-1:0] test_name;
  int test_errs;
  int n_errors;
  int n_tests;
  int n_bad_tests;
  int start_cnt;
  int unsigned wd_cycles = 0;
  int unsigned wd_limit = 200;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  intra_ctrl u_intra_ctrl (
    .clk(clk), .rstn(rstn), .start_i(start_i), .partition_i(partition_i),
    .md_cena_o(md_cena_o), .md_addr_o(md_addr_o), .md_data_i(md_data_i),
    .loop_size_o(loop_size_o), .loop_position_o(loop_position_o),
    .loop_mode_o(loop_mode_o), .ref_start_o(ref_start_o), .ref_done_i(ref_done_i),
    .ref_ready_i(ref_ready_i), .pre_start_o(pre_start_o), .pre_4x4_x_o(pre_4x4_x_o),
    .pre_4x4_y_o(pre_4x4_y_o), .done_o(done_o)
  );

  // mode memory, one cycle read latency
  always @(posedge clk) begin
    if (md_cena_o) begin
      md_data_i <= #1 mode_mem[md_addr_o];
    end
  end

  always @(posedge clk) begin
    if (ref_start_o) begin
      start_cnt <= start_cnt + 1;
    end
  end

  // watchdog, limit is rearmed per test
  initial begin
    while (wd_cycles <= wd_limit) begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("timeout: %0s made no progress within %0d cycles", test_name, wd_limit);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic block_size_e leaf_size(logic [PART_W-1:0] part, logic [POS_W-1:0] pos);
    block_size_e size;
    if (!part[PART_32_LSB + (pos >> 6)]) begin
      size = SIZE_32;
    end else if (!part[PART_16_LSB + (pos >> 4)]) begin
      size = SIZE_16;
    end else if (!part[PART_08_LSB + (pos >> 2)]) begin
      size = SIZE_08;
    end else begin
      size = SIZE_04;
    end
    return size;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0s: %0s expected %0b actual %0b", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_size(input string what, input block_size_e exp, input block_size_e act);
    if (act !== exp) begin
      $display("ERROR %0s: %0s expected %0d actual %0d", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_pos(input string what, input logic [POS_W-1:0] exp,
                           input logic [POS_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %0s: %0s expected %0d actual %0d", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_mode(input string what, input logic [MODE_W-1:0] exp,
                            input logic [MODE_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %0s: %0s expected %0d actual %0d", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_coord(input string what, input logic [COORD_W-1:0] exp,
                             input logic [COORD_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %0s: %0s expected %0d actual %0d", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  // expected leaf list in z-order
  task automatic build_model(input logic [PART_W-1:0] part);
    logic [POS_W-1:0] pos;
    pos = '0;
    exp_count = 0;
    do begin
      exp_pos[exp_count] = pos;
      exp_size[exp_count] = leaf_size(part, pos);
      pos = pos + (8'd1 << (2 * exp_size[exp_count]));
      exp_count++;
    end while ((pos != '0) && (exp_count < 256));
  endtask

  task automatic run_burst(input int n);
    int cols;
    int bpr;
    int beats;
    logic [COORD_W-1:0] x0;
    logic [COORD_W-1:0] y0;
    logic [COORD_W-1:0] ex;
    logic [COORD_W-1:0] ey;
    cols = 1 << exp_size[n];
    bpr = (cols > 1) ? cols / 2 : 1;
    // column from even position bits, row from odd ones
    for (int b = 0; b < COORD_W; b++) begin
      x0[b] = exp_pos[n][2*b];
      y0[b] = exp_pos[n][2*b+1];
    end
    ex = x0;
    ey = y0;
    beats = 0;
    while (pre_start_o && (beats < 64)) begin
      check_coord("pre_4x4_x_o", ex, pre_4x4_x_o);
      check_coord("pre_4x4_y_o", ey, pre_4x4_y_o);
      beats++;
      if ((bpr == 1) || (beats % bpr == 0)) begin
        ex = x0;
        ey = ey + 4'd1;
      end else begin
        ex = ex + 4'd2;
      end
      tick();
    end
    if (beats != ((cols > 1) ? cols * cols / 2 : 1)) begin
      $display("ERROR %0s: burst beats expected %0d actual %0d", test_name,
               (cols > 1) ? cols * cols / 2 : 1, beats);
      test_errs++;
    end
  endtask

  task automatic run_test(input logic [PART_W-1:0] part, input int trace_count);
    build_model(part);
    if (exp_count != trace_count) begin
      $display("ERROR %0s: block count expected %0d actual %0d", test_name, trace_count,
               exp_count);
      test_errs++;
    end
    wd_cycles = 0;
    wd_limit = exp_count * 80 + 200;
    start_cnt = 0;
    partition_i = part;
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    for (int n = 0; n < exp_count; n++) begin
      while (!ref_start_o) begin
        tick();
      end
      check_flag("md_cena_o", 1'b1, md_cena_o);
      check_pos("loop_position_o", exp_pos[n], loop_position_o);
      check_size("loop_size_o", exp_size[n], loop_size_o);
      check_pos("md_addr_o", exp_pos[n], md_addr_o);
      tick();
      check_flag("ref_start_o", 1'b0, ref_start_o);
      check_flag("md_cena_o", 1'b0, md_cena_o);
      tick();
      check_mode("loop_mode_o", mode_mem[exp_pos[n]], loop_mode_o);
      tick();
      ref_ready_i = 1'b1;
      tick();
      ref_ready_i = 1'b0;
      check_flag("pre_start_o", 1'b1, pre_start_o);
      run_burst(n);
      ref_done_i = 1'b1;
      tick();
      ref_done_i = 1'b0;
      check_flag("done_o", n == exp_count - 1, done_o);
    end
    tick();
    check_flag("done_o", 1'b0, done_o);
    check_flag("ref_start_o", 1'b0, ref_start_o);
    if (start_cnt != exp_count) begin
      $display("ERROR %0s: ref_start count expected %0d actual %0d", test_name, exp_count,
               start_cnt);
      test_errs++;
    end
  endtask

  task automatic close_test();
    $display("%0s: %0d blocks, %0d mismatches", test_name, exp_count, test_errs);
    n_tests++;
    n_errors += test_errs;
    if (test_errs != 0) begin
      n_bad_tests++;
    end
    test_errs = 0;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int fd;
    int code;
    logic [LINE_W-1:0] line;
    logic [7:0] first_ch;
    logic [PART_W-1:0] part;
    int trace_count;
    logic [31:0] seed;
    start_i = 1'b0;
    partition_i = '0;
    md_data_i = '0;
    ref_done_i = 1'b0;
    ref_ready_i = 1'b0;
    n_errors = 0;
    n_tests = 0;
    n_bad_tests = 0;
    test_errs = 0;
    exp_count = 0;
    seed = 32'h988f_4ed8;
    for (int i = 0; i < 256; i++) begin
      seed = lcg_next(seed);
      mode_mem[i] = seed[31:26];
    end
    @(posedge rstn);
    tick();
    test_name = "reset";
    check_flag("md_cena_o", 1'b0, md_cena_o);
    check_flag("ref_start_o", 1'b0, ref_start_o);
    check_flag("pre_start_o", 1'b0, pre_start_o);
    check_flag("done_o", 1'b0, done_o);
    check_pos("md_addr_o", '0, md_addr_o);
    check_pos("loop_position_o", '0, loop_position_o);
    check_size("loop_size_o", SIZE_04, loop_size_o);
    check_mode("loop_mode_o", '0, loop_mode_o);
    check_coord("pre_4x4_x_o", '0, pre_4x4_x_o);
    check_coord("pre_4x4_y_o", '0, pre_4x4_y_o);
    close_test();
    fd = $fopen("tb/intra_ctrl_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tb/intra_ctrl_trace.txt");
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          code = $sscanf(line, " %c", first_ch);
          // skip blank and comment lines
          if ((code == 1) && (first_ch != "#")) begin
            code = $sscanf(line, "%s %h %d", test_name, part, trace_count);
            if (code != 3) begin
              $display("a trace line has the wrong number of fields");
              n_errors++;
            end else begin
              run_test(part, trace_count);
              close_test();
              repeat (3) tick();
            end
          end
        end
      end
      $fclose(fd);
    end
    $display("tests %0d, with mismatches %0d, errors %0d", n_tests, n_bad_tests, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* tb/intra_ctrl_trace.txt */
# name, partition word in hex (bit 0 is the 64 split),
# expected leaf count in decimal
unsplit 1 4
all_16 1f 16
all_08 1fffff 64
full_split 1fffffffffffffffffffff 256
one_quad 5 7
corner_4x4 200023 13
mixed 40002011f 25

/* build.f */
logic/intra_size_pkg.sv
logic/intra_ctrl_pkg.sv
logic/intra_quadtree_walker.sv
logic/intra_block_info_reg.sv
logic/intra_pred_sequencer.sv
logic/intra_ctrl.sv
tb/tb_clk_gen.sv
tb/tb_intra_ctrl.sv

/* Bender.yml */
package:
  name: intra_ctrl

sources:
  # packages first, then the design bottom up
  - files:
      - logic/intra_size_pkg.sv
      - logic/intra_ctrl_pkg.sv
      - logic/intra_quadtree_walker.sv
      - logic/intra_block_info_reg.sv
      - logic/intra_pred_sequencer.sv
      - logic/intra_ctrl.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_intra_ctrl.sv
